/* src/synth_consts.svh */
// Sizes and APB offsets for the operator engine; operator count must be a power of two
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// Operator array and datapath widths
`define NUM_VOICE_OPERATORS 16
`define OP_ID_WIDTH         4
`define PHASE_WIDTH         16
`define SAMPLE_WIDTH        16

// APB bus widths
`define APB_ADDR_WIDTH      12
`define APB_DATA_WIDTH      32

// Output buffering, must stay a power of two
`define SAMPLE_FIFO_DEPTH   4

// Register map, operator k sits at REG_OP_BASE + 4*k
`define REG_CONTROL         12'h000
`define REG_STATUS          12'h004
`define REG_OP_BASE         12'h100

`endif

/* src/synth_types_pkg.sv */
// Datapath types for the operator engine; widths come from synth_consts.svh
`include "synth_consts.svh"

package synth_types_pkg;

    // Index of one of the voice operators
    typedef logic [`OP_ID_WIDTH-1:0] VoiceOperatorID_t;

    // Phase wraps on overflow, so it is kept unsigned
    typedef logic unsigned [`PHASE_WIDTH-1:0] phase_t;

    // Output samples are two's complement
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Waveform select per operator
    // Code 3 is not named here and the shaper treats it as saw
    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2
    } waveform_t;

endpackage

/* src/apb_map_pkg.sv */
// APB word types and register kinds; register offsets themselves live in synth_consts.svh
`include "synth_consts.svh"

package apb_map_pkg;

    // Address and data words of the configuration bus
    typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

    // One strobe bit per byte lane of the data word
    typedef logic [`APB_DATA_WIDTH/8-1:0] apb_strb_t;

    // Result of decoding one APB address
    // Invalid covers unmapped offsets and operator slots past the last one
    typedef enum logic [1:0] {
        REG_KIND_CONTROL  = 2'd0,
        REG_KIND_STATUS   = 2'd1,
        REG_KIND_OPERATOR = 2'd2,
        REG_KIND_INVALID  = 2'd3
    } reg_kind_t;

endpackage

/* src/apb_config_slave.sv */
// APB4 slave with zero wait states; operator registers are write-only and read as zero
`timescale 1ns/1ps
`include "synth_consts.svh"

module apb_config_slave
    import apb_map_pkg::*, synth_types_pkg::*;
(
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  logic             i_psel,
    input  logic             i_penable,
    input  logic             i_pwrite,
    input  apb_addr_t        i_paddr,
    input  apb_data_t        i_pwdata,
    input  apb_strb_t        i_pstrb,
    output apb_data_t        o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    output logic             o_run,
    output logic [1:0]       o_step_write_enable,
    output logic             o_wave_write_enable,
    output VoiceOperatorID_t o_config_addr,
    output apb_data_t        o_config_data,
    output waveform_t        o_wave_data,
    output logic             o_overflow_clear,
    input  logic             i_overflow
);

    reg_kind_t w_kind;
    apb_addr_t w_op_offset;
    logic      w_access;
    logic      w_write;

    // Address decode
    // ------------------------------
    // Operator slots are word aligned, anything else in the window is an error
    assign w_op_offset = i_paddr - `REG_OP_BASE;

    always_comb begin
        w_kind = REG_KIND_INVALID;
        if (i_paddr == `REG_CONTROL) begin
            w_kind = REG_KIND_CONTROL;
        end else if (i_paddr == `REG_STATUS) begin
            w_kind = REG_KIND_STATUS;
        end else if (i_paddr >= `REG_OP_BASE &&
                     w_op_offset < apb_addr_t'(4 * `NUM_VOICE_OPERATORS) &&
                     i_paddr[1:0] == 2'b00) begin
            w_kind = REG_KIND_OPERATOR;
        end
    end

    // Access phase qualifiers
    // ------------------------------
    // Every strobe below is only live in the access cycle
    assign w_access  = i_psel && i_penable;
    assign w_write   = w_access && i_pwrite && (w_kind != REG_KIND_INVALID);
    assign o_pready  = 1'b1;
    assign o_pslverr = w_access && (w_kind == REG_KIND_INVALID);

    // Run bit sits in byte lane 0 of the control word
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            o_run <= 1'b0;
        end else if (w_write && w_kind == REG_KIND_CONTROL && i_pstrb[0]) begin
            o_run <= i_pwdata[0];
        end
    end

    // Status is write-one-to-clear on bit 0
    assign o_overflow_clear = w_write && (w_kind == REG_KIND_STATUS) &&
                              i_pstrb[0] && i_pwdata[0];

    // Lanes 0 and 1 carry the phase step, lane 2 carries the waveform
    assign o_step_write_enable = (w_write && w_kind == REG_KIND_OPERATOR) ?
                                 i_pstrb[1:0] : 2'b00;
    assign o_wave_write_enable = w_write && (w_kind == REG_KIND_OPERATOR) && i_pstrb[2];
    assign o_config_addr       = w_op_offset[`OP_ID_WIDTH+1:2];
    assign o_config_data       = i_pwdata;
    assign o_wave_data         = waveform_t'(i_pwdata[17:16]);

    // Read mux, only control and status hold readable state
    always_comb begin
        case (w_kind)
            REG_KIND_CONTROL: o_prdata = {{(`APB_DATA_WIDTH-1){1'b0}}, o_run};
            REG_KIND_STATUS:  o_prdata = {{(`APB_DATA_WIDTH-1){1'b0}}, i_overflow};
            default:          o_prdata = '0;
        endcase
    end

    // The host may only raise penable inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge i_Clock) disable iff (!i_rst_n) i_penable |-> i_psel
    );

endmodule

/* src/operator_scheduler.sv */
// Round-robin operator source; stopping run holds the next ID so the sequence resumes in order
`timescale 1ns/1ps
`include "synth_consts.svh"

module operator_scheduler
    import synth_types_pkg::*;
(
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  logic             i_run,
    output VoiceOperatorID_t o_operator,
    output logic             o_valid
);

    // ID that will be issued on the next cycle where run is high
    VoiceOperatorID_t r_next_id;

    // One operator per cycle while running
    // The counter wraps naturally from the last operator back to 0
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            r_next_id  <= '0;
            o_operator <= '0;
            o_valid    <= 1'b0;
        end else begin
            o_valid <= i_run;
            if (i_run) begin
                o_operator <= r_next_id;
                r_next_id  <= r_next_id + 1'b1;
            end
        end
    end

endmodule

/* src/stage_phase_accumulation.sv */
// Two-cycle phase accumulator; the same operator must not be issued on consecutive cycles
`timescale 1ns/1ps
`include "synth_consts.svh"

module stage_phase_accumulation
    import synth_types_pkg::*;
(
    input  logic                     i_Clock,
    input  logic                     i_rst_n,
    input  VoiceOperatorID_t         i_VoiceOperator,
    input  logic                     i_valid,
    output phase_t                   o_Phase,
    output VoiceOperatorID_t         o_VoiceOperator,
    output logic                     o_valid,
    input  logic [1:0]               i_PhaseStepConfigWriteEnable,
    input  VoiceOperatorID_t         i_PhaseStepConfigWriteAddr,
    input  logic [`PHASE_WIDTH-1:0]  i_PhaseStepConfigWriteData
);

    // Unsigned accumulators so that overflow wraps the phase
    phase_t r_accumulators [`NUM_VOICE_OPERATORS];
    phase_t r_step_config  [`NUM_VOICE_OPERATORS];

    // Stage 1 registers
    VoiceOperatorID_t r_operator;
    phase_t           r_acc_phase;
    phase_t           r_step;
    logic             r_valid;

    phase_t w_stepped_phase;

    assign w_stepped_phase = r_acc_phase + r_step;

    // Array state
    // ------------------------------
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            for (int k = 0; k < `NUM_VOICE_OPERATORS; k++) begin
                r_accumulators[k] <= '0;
                r_step_config[k]  <= '0;
            end
        end else begin
            // Lane 0 is the low step byte, lane 1 the high one
            if (i_PhaseStepConfigWriteEnable[0]) begin
                r_step_config[i_PhaseStepConfigWriteAddr][7:0] <= i_PhaseStepConfigWriteData[7:0];
            end
            if (i_PhaseStepConfigWriteEnable[1]) begin
                r_step_config[i_PhaseStepConfigWriteAddr][15:8] <= i_PhaseStepConfigWriteData[15:8];
            end
            // Stage 2 result feeds back into the array
            if (r_valid) begin
                r_accumulators[r_operator] <= w_stepped_phase;
            end
        end
    end

    // Pipeline
    // ------------------------------
    always_ff @(posedge i_Clock) begin
        // Stage 1 fetches the accumulator and the step
        r_acc_phase <= r_accumulators[i_VoiceOperator];
        r_step      <= r_step_config[i_VoiceOperator];
        r_operator  <= i_VoiceOperator;
        // Stage 2 presents the new phase
        o_Phase         <= w_stepped_phase;
        o_VoiceOperator <= r_operator;
    end

    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            r_valid <= i_valid;
            o_valid <= r_valid;
        end
    end

    // An accepted operator leaves exactly two cycles later
    a_two_cycle_latency: assert property (
        @(posedge i_Clock) disable iff (!i_rst_n) o_valid == $past(i_valid, 2)
    );

endmodule

/* src/stage_waveform.sv */
// One-cycle phase-to-sample shaper; square and triangle stay symmetric around zero
`timescale 1ns/1ps
`include "synth_consts.svh"

module stage_waveform
    import synth_types_pkg::*;
(
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  phase_t           i_phase,
    input  VoiceOperatorID_t i_operator,
    input  logic             i_valid,
    input  logic             i_wave_write_enable,
    input  VoiceOperatorID_t i_wave_addr,
    input  waveform_t        i_wave_data,
    output sample_t          o_sample,
    output VoiceOperatorID_t o_operator,
    output logic             o_valid
);

    waveform_t r_wave [`NUM_VOICE_OPERATORS];

    phase_t  w_tri;
    sample_t w_sample;

    // Waveform select per operator, saw after reset
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            for (int k = 0; k < `NUM_VOICE_OPERATORS; k++) begin
                r_wave[k] <= WAVE_SAW;
            end
        end else if (i_wave_write_enable) begin
            r_wave[i_wave_addr] <= i_wave_data;
        end
    end

    // Triangle ramps twice per phase cycle
    assign w_tri = {i_phase[`PHASE_WIDTH-2:0], 1'b0};

    // Shaper
    // ------------------------------
    always_comb begin
        case (r_wave[i_operator])
            WAVE_SQUARE:   w_sample = i_phase[`PHASE_WIDTH-1] ? -16'sd32767 : 16'sd32767;
            WAVE_TRIANGLE: w_sample = i_phase[`PHASE_WIDTH-1] ?
                                      sample_t'(16'h7fff - w_tri) :
                                      sample_t'(w_tri - 16'h8000);
            // Flipping the top bit recentres the ramp on zero
            default:       w_sample = sample_t'({~i_phase[`PHASE_WIDTH-1],
                                                 i_phase[`PHASE_WIDTH-2:0]});
        endcase
    end

    always_ff @(posedge i_Clock) begin
        o_sample   <= w_sample;
        o_operator <= i_operator;
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

/* src/sample_fifo.sv */
// Sample FIFO that never stalls its writer; DEPTH must be a power of two and at least 2
`timescale 1ns/1ps
`include "synth_consts.svh"

module sample_fifo
    import synth_types_pkg::*;
#(
    parameter int DEPTH = `SAMPLE_FIFO_DEPTH
) (
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  sample_t          i_sample,
    input  VoiceOperatorID_t i_operator,
    input  logic             i_valid,
    output logic             o_sample_valid,
    output sample_t          o_sample_data,
    output VoiceOperatorID_t o_sample_operator,
    input  logic             i_sample_ready,
    output logic             o_overflow,
    input  logic             i_overflow_clear
);

    localparam int AW = $clog2(DEPTH);

    sample_t          r_sample_mem [DEPTH];
    VoiceOperatorID_t r_op_mem     [DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [AW:0] r_wr_ptr;
    logic [AW:0] r_rd_ptr;

    logic w_full;
    logic w_push;
    logic w_pop;

    assign w_full = (r_wr_ptr[AW] != r_rd_ptr[AW]) && (r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);
    assign w_push = i_valid && !w_full;
    assign w_pop  = o_sample_valid && i_sample_ready;

    assign o_sample_valid    = (r_wr_ptr != r_rd_ptr);
    assign o_sample_data     = r_sample_mem[r_rd_ptr[AW-1:0]];
    assign o_sample_operator = r_op_mem[r_rd_ptr[AW-1:0]];

    always_ff @(posedge i_Clock) begin
        if (w_push) begin
            r_sample_mem[r_wr_ptr[AW-1:0]] <= i_sample;
            r_op_mem[r_wr_ptr[AW-1:0]]     <= i_operator;
        end
    end

    // Pointers and sticky overflow
    // ------------------------------
    // A new drop wins over a clear in the same cycle
    always_ff @(posedge i_Clock) begin
        if (!i_rst_n) begin
            r_wr_ptr   <= '0;
            r_rd_ptr   <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (w_push) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (w_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            if (i_valid && w_full) begin
                o_overflow <= 1'b1;
            end else if (i_overflow_clear) begin
                o_overflow <= 1'b0;
            end
        end
    end

    a_no_write_when_full: assert property (
        @(posedge i_Clock) disable iff (!i_rst_n) w_full |=> $stable(r_wr_ptr)
    );

endmodule

/* src/synth_top.sv */
// Operator engine top; the sample port has no stall path back into the pipeline
`timescale 1ns/1ps
`include "synth_consts.svh"

module synth_top
    import apb_map_pkg::*, synth_types_pkg::*;
(
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  logic             i_psel,
    input  logic             i_penable,
    input  logic             i_pwrite,
    input  apb_addr_t        i_paddr,
    input  apb_data_t        i_pwdata,
    input  apb_strb_t        i_pstrb,
    output apb_data_t        o_prdata,
    output logic             o_pready,
    output logic             o_pslverr,
    output logic             o_sample_valid,
    output sample_t          o_sample_data,
    output VoiceOperatorID_t o_sample_operator,
    input  logic             i_sample_ready
);

    // Configuration strobes from the slave
    logic             w_run;
    logic [1:0]       w_step_we;
    logic             w_wave_we;
    VoiceOperatorID_t w_cfg_addr;
    apb_data_t        w_cfg_data;
    waveform_t        w_wave_data;
    logic             w_ovf_clear;
    logic             w_overflow;

    // Datapath between stages
    VoiceOperatorID_t w_sched_op;
    logic             w_sched_valid;
    phase_t           w_phase;
    VoiceOperatorID_t w_acc_op;
    logic             w_acc_valid;
    sample_t          w_sample;
    VoiceOperatorID_t w_wave_op;
    logic             w_wave_valid;

    apb_config_slave u_apb (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pstrb(i_pstrb),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_run(w_run), .o_step_write_enable(w_step_we), .o_wave_write_enable(w_wave_we),
        .o_config_addr(w_cfg_addr), .o_config_data(w_cfg_data), .o_wave_data(w_wave_data),
        .o_overflow_clear(w_ovf_clear), .i_overflow(w_overflow)
    );

    operator_scheduler u_sched (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n), .i_run(w_run),
        .o_operator(w_sched_op), .o_valid(w_sched_valid)
    );

    // Only the low half of the data word carries the step
    stage_phase_accumulation u_acc (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_VoiceOperator(w_sched_op), .i_valid(w_sched_valid),
        .o_Phase(w_phase), .o_VoiceOperator(w_acc_op), .o_valid(w_acc_valid),
        .i_PhaseStepConfigWriteEnable(w_step_we),
        .i_PhaseStepConfigWriteAddr(w_cfg_addr),
        .i_PhaseStepConfigWriteData(w_cfg_data[`PHASE_WIDTH-1:0])
    );

    stage_waveform u_wave (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_phase(w_phase), .i_operator(w_acc_op), .i_valid(w_acc_valid),
        .i_wave_write_enable(w_wave_we), .i_wave_addr(w_cfg_addr), .i_wave_data(w_wave_data),
        .o_sample(w_sample), .o_operator(w_wave_op), .o_valid(w_wave_valid)
    );

    sample_fifo #(.DEPTH(`SAMPLE_FIFO_DEPTH)) u_fifo (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_sample(w_sample), .i_operator(w_wave_op), .i_valid(w_wave_valid),
        .o_sample_valid(o_sample_valid), .o_sample_data(o_sample_data),
        .o_sample_operator(o_sample_operator), .i_sample_ready(i_sample_ready),
        .o_overflow(w_overflow), .i_overflow_clear(w_ovf_clear)
    );

endmodule

/* verification/tb_synth_top.sv */
// Trace-driven testbench; needs the trace to leave no sample in flight when it reaches END
`timescale 1ns/1ps
`include "synth_consts.svh"

module tb_synth_top
    import apb_map_pkg::*, synth_types_pkg::*;
();

    localparam int APB_TIMEOUT     = 16;
    localparam int COLLECT_TIMEOUT = 400;

    // DUT connections
    logic             i_Clock = 1'b0;
    logic             i_rst_n;
    logic             i_psel;
    logic             i_penable;
    logic             i_pwrite;
    apb_addr_t        i_paddr;
    apb_data_t        i_pwdata;
    apb_strb_t        i_pstrb;
    apb_data_t        o_prdata;
    logic             o_pready;
    logic             o_pslverr;
    logic             o_sample_valid;
    sample_t          o_sample_data;
    VoiceOperatorID_t o_sample_operator;
    logic             i_sample_ready;

    // Reference model, one entry per operator
    phase_t     step_m [`NUM_VOICE_OPERATORS] = '{default: '0};
    logic [1:0] wave_m [`NUM_VOICE_OPERATORS] = '{default: '0};
    phase_t     acc_m  [`NUM_VOICE_OPERATORS] = '{default: '0};
    int         next_op = 0;

    // Sample counts shared by the trace reader and the output monitor
    int     rx_count   = 0;
    int     rx_target  = 0;
    int     ready_mode = 0;
    integer seed       = 99;

    int reg_errors    = 0;
    int sample_errors = 0;
    int other_errors  = 0;

    always #2 i_Clock = ~i_Clock;

    synth_top u_dut (
        .i_Clock(i_Clock), .i_rst_n(i_rst_n),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_pstrb(i_pstrb),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_sample_valid(o_sample_valid), .o_sample_data(o_sample_data),
        .o_sample_operator(o_sample_operator), .i_sample_ready(i_sample_ready)
    );

    // Model rules
    // ------------------------------
    // Saw is the phase moved down by half the range
    function automatic int shape_sample(input phase_t phase, input logic [1:0] wave);
        int p;
        int t;
        p = int'(phase);
        t = (p % 32768) * 2;
        case (wave)
            2'd1: return (p < 32768) ? 32767 : -32767;
            2'd2: return (p < 32768) ? t - 32768 : 32767 - t;
            default: return p - 32768;
        endcase
    endfunction

    // Register kind as the address map defines it
    function automatic reg_kind_t kind_of(input apb_addr_t addr);
        if (addr == `REG_CONTROL) begin
            return REG_KIND_CONTROL;
        end
        if (addr == `REG_STATUS) begin
            return REG_KIND_STATUS;
        end
        if (addr >= `REG_OP_BASE && addr[1:0] == 2'b00 &&
            addr < `REG_OP_BASE + apb_addr_t'(4 * `NUM_VOICE_OPERATORS)) begin
            return REG_KIND_OPERATOR;
        end
        return REG_KIND_INVALID;
    endfunction

    // Bus driver
    // ------------------------------
    // Setup then access, with read data taken mid access cycle
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t data,
                                input apb_strb_t strb, output apb_data_t rdata,
                                output logic slverr);
        int waited;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = data;
        i_pstrb   = strb;
        @(posedge i_Clock);
        #1;
        i_penable = 1'b1;
        #1;
        waited = 0;
        while (!o_pready && waited < APB_TIMEOUT) begin
            @(posedge i_Clock);
            #2;
            waited++;
        end
        assert (o_pready) else begin
            $display("APB access to %h never saw pready within %0d cycles", addr, waited);
            other_errors++;
        end
        rdata  = o_prdata;
        slverr = o_pslverr;
        @(posedge i_Clock);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    // Operator writes land in the model lane by lane
    task automatic apply_write(input apb_addr_t addr, input apb_data_t data, input apb_strb_t strb);
        VoiceOperatorID_t op;
        op = VoiceOperatorID_t'((addr - `REG_OP_BASE) >> 2);
        if (strb[0]) begin
            step_m[op][7:0] = data[7:0];
        end
        if (strb[1]) begin
            step_m[op][15:8] = data[15:8];
        end
        if (strb[2]) begin
            wave_m[op] = data[17:16];
        end
    endtask

    // Waits until count more samples have passed the monitor
    task automatic collect_samples(input int count, input int mode, output logic ok);
        int waited;
        ready_mode = mode;
        rx_target  = rx_target + count;
        waited     = 0;
        while (rx_count < rx_target && waited < COLLECT_TIMEOUT) begin
            @(posedge i_Clock);
            #1;
            waited++;
        end
        ok = (rx_count >= rx_target);
        assert (ok) else begin
            $display("Sample output stalled, %0d of %0d samples arrived in %0d cycles",
                     rx_count, rx_target, waited);
            other_errors++;
        end
    endtask

    // Output side
    // ------------------------------
    // Each transfer is the next operator in round-robin order
    task automatic check_sample();
        VoiceOperatorID_t exp_op;
        int               exp_val;
        int               act_val;
        exp_op         = VoiceOperatorID_t'(next_op);
        acc_m[exp_op]  = acc_m[exp_op] + step_m[exp_op];
        exp_val        = shape_sample(acc_m[exp_op], wave_m[exp_op]);
        act_val        = int'(o_sample_data);
        assert (o_sample_operator == exp_op) else begin
            $display("error: sample %0d operator: expected %0d, actual %0d",
                     rx_count, exp_op, o_sample_operator);
            sample_errors++;
        end
        assert (act_val == exp_val) else begin
            $display("error: sample %0d value of operator %0d: expected %0d, actual %0d",
                     rx_count, exp_op, exp_val, act_val);
            sample_errors++;
        end
        next_op  = (next_op + 1) % `NUM_VOICE_OPERATORS;
        rx_count = rx_count + 1;
    endtask

    // Valid and ready are both settled by 2 ns after the edge
    always @(posedge i_Clock) begin
        #2;
        if (o_sample_valid === 1'b1 && i_sample_ready === 1'b1) begin
            check_sample();
        end
    end

    // Ready follows the mode of the last collect command, 2 is random
    // The mode is taken at the edge, so a new collect command acts from the next cycle
    initial begin
        int rnd;
        int mode_now;
        i_sample_ready = 1'b0;
        forever begin
            @(posedge i_Clock);
            mode_now = ready_mode;
            #1;
            case (mode_now)
                1: i_sample_ready = 1'b1;
                2: begin
                    rnd            = $random(seed);
                    i_sample_ready = rnd[0];
                end
                default: i_sample_ready = 1'b0;
            endcase
        end
    end

    // Trace reader
    // ------------------------------
    initial begin
        int        fd;
        int        code;
        int        a;
        int        b;
        int        c;
        string     line;
        byte       cmd;
        logic      done;
        logic      ok;
        logic      slverr;
        logic      exp_err;
        apb_data_t rdata;
        apb_addr_t addr;
        reg_kind_t kind;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_pstrb   = '0;
        repeat (2) @(posedge i_Clock);
        #1;
        i_rst_n = 1'b1;
        fd = $fopen("verification/phase_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verification/phase_trace.txt");
            other_errors++;
        end else begin
            done = 1'b0;
            while (!done && !$feof(fd)) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2) begin
                    continue;
                end
                cmd  = line[0];
                a    = 0;
                b    = 0;
                c    = 0;
                code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                addr = apb_addr_t'(a);
                kind = kind_of(addr);
                case (cmd)
                    "W": begin
                        apb_transfer(1'b1, addr, apb_data_t'(b), apb_strb_t'(c), rdata, slverr);
                        exp_err = (kind == REG_KIND_INVALID);
                        assert (slverr == exp_err) else begin
                            $display("error: write %s at %h pslverr: expected %0d, actual %0d",
                                     kind.name(), addr, exp_err, slverr);
                            reg_errors++;
                        end
                        if (kind == REG_KIND_OPERATOR) begin
                            apply_write(addr, apb_data_t'(b), apb_strb_t'(c));
                        end
                    end
                    "R": begin
                        apb_transfer(1'b0, addr, '0, '0, rdata, slverr);
                        assert (rdata == apb_data_t'(b)) else begin
                            $display("error: read %s at %h data: expected %h, actual %h",
                                     kind.name(), addr, apb_data_t'(b), rdata);
                            reg_errors++;
                        end
                        assert (slverr == (c != 0)) else begin
                            $display("error: read %s at %h pslverr: expected %0d, actual %0d",
                                     kind.name(), addr, (c != 0), slverr);
                            reg_errors++;
                        end
                    end
                    "C": begin
                        collect_samples(a, b, ok);
                        done = !ok;
                    end
                    "E": done = 1'b1;
                    default: ;
                endcase
            end
            $fclose(fd);
        end
        assert (rx_count == rx_target) else begin
            $display("Expected %0d samples in total but %0d arrived", rx_target, rx_count);
            other_errors++;
        end
        $display("Error counts: register %0d, sample %0d, other %0d",
                 reg_errors, sample_errors, other_errors);
        if (reg_errors == 0 && sample_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verification/phase_trace.txt */
# Columns, all numbers hex: W addr data strb | R addr expected_data expected_slverr
# C count ready (ready 0 low, 1 high, 2 random) | END stops the trace
R 000 00000000 0
R 004 00000000 0
R 00C 00000000 1
R 140 00000000 1
W 008 00000001 1
W 100 00009000 3
W 104 0000C350 3
W 108 00000400 3
W 10C 0000FFFF 3
W 110 00007FFF 3
W 114 00001234 3
W 118 0000A5A5 3
W 11C 00008001 3
W 120 00004000 3
W 124 0000E000 3
W 128 00000101 3
W 12C 0000BEEF 3
W 130 00002AAA 3
W 134 0000F00D 3
W 138 00006000 3
W 13C 0000FFF0 3
R 104 00000000 0
R 000 00000000 0
W 000 00000001 1
C 14 1
W 000 00000000 1
C 7 1
W 104 0000AB00 2
W 108 00010000 4
W 10C 00020000 4
W 110 00030000 4
W 114 00020000 4
W 000 00000001 1
C 14 1
W 000 00000000 1
C 7 1
W 000 00000001 1
R 000 00000001 0
W 000 00000000 1
C 4 2
W 000 00000001 1
R 000 00000001 0
W 000 00000000 1
C 4 2
C 0 0
W 000 00000001 1
R 000 00000001 0
R 000 00000001 0
R 000 00000001 0
W 000 00000000 1
R 000 00000000 0
R 004 00000001 0
C 4 1
W 004 00000001 1
R 004 00000000 0
END

/* sources.f */
+incdir+src
src/synth_types_pkg.sv
src/apb_map_pkg.sv
src/apb_config_slave.sv
src/operator_scheduler.sv
src/stage_phase_accumulation.sv
src/stage_waveform.sv
src/sample_fifo.sv
src/synth_top.sv
verification/tb_synth_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator from the project root, run, and decide on the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_synth_top -f sources.f \
    && ./obj_dir/Vtb_synth_top | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
